//--- flist.f
+incdir+rtl
rtl/be_instr_pkg.sv
rtl/be_ooo_pkg.sv
rtl/be_if.sv
rtl/rename_stage.sv
rtl/issue_table.sv
rtl/execute_stage.sv
rtl/commit_stage.sv
rtl/be_top.sv
dv/be_tb.sv

//--- Makefile
TOP := be_tb

.PHONY: sim clean

sim:
	verilator --binary -Wno-fatal --top-module $(TOP) -f flist.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

//--- dv/be_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "be_consts.svh"

module be_tb;

  import be_instr_pkg::*;

  localparam int NUM_RANDOM  = 300;
  localparam int NUM_INSTR   = NUM_RANDOM + 40;
  // worst case cycles per instruction, drain gaps included
  localparam int MAX_LAT     = 24;
  localparam int CLK_PERIOD  = 100;
  localparam int WATCHDOG_NS = (NUM_INSTR * MAX_LAT + 200) * CLK_PERIOD;

  logic                    clk_i;
  logic                    rst_n_i;
  decoded_t                decoded_i;
  logic                    decoded_v_i;
  logic                    rename_decode_ready_o;
  logic                    be_fe_mispredict_o;
  logic [`WORD_SIZE-1:0]   be_fe_redirected_pc_o;
  logic                    commit_v_o;
  logic [`ARCH_REG_W-1:0]  commit_rd_o;
  logic [`WORD_SIZE-1:0]   commit_data_o;

  // architectural state of the reference model
  logic [`WORD_SIZE-1:0]   model_rf [`NUM_ARCH_REG];
  logic [`ARCH_REG_W-1:0]  exp_rd   [$];
  logic [`WORD_SIZE-1:0]   exp_val  [$];
  logic [`WORD_SIZE-1:0]   exp_pc   [$];
  logic [`WORD_SIZE-1:0]   next_pc;
  logic [`WORD_SIZE-1:0]   last_target;
  logic [31:0]             lfsr;
  int                      stall_cycles;

  be_top i_dut
    (  .clk_i                 (clk_i)
     , .rst_n_i               (rst_n_i)
     , .decoded_i             (decoded_i)
     , .decoded_v_i           (decoded_v_i)
     , .rename_decode_ready_o (rename_decode_ready_o)
     , .be_fe_mispredict_o    (be_fe_mispredict_o)
     , .be_fe_redirected_pc_o (be_fe_redirected_pc_o)
     , .commit_v_o            (commit_v_o)
     , .commit_rd_o           (commit_rd_o)
     , .commit_data_o         (commit_data_o)
    );

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  task automatic stop_with_fail(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  function automatic string err_line(input string msg);
    return $sformatf("[ERROR] %0d ns: %s", $time, msg);
  endfunction

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic decoded_t alu_op(input op_e op, input int rd, input int rs1,
                                      input int rs2, input logic [31:0] imm);
    decoded_t d;
    d             = '0;
    d.op          = op;
    d.rd          = rd[`ARCH_REG_W-1:0];
    d.rs1         = rs1[`ARCH_REG_W-1:0];
    d.rs2         = rs2[`ARCH_REG_W-1:0];
    d.operand.imm = imm;
    return d;
  endfunction

  function automatic decoded_t branch(input br_cond_e cond, input int rs1, input int rs2,
                                      input int offset);
    decoded_t d;
    d                   = '0;
    d.op                = OP_BR;
    d.rs1               = rs1[`ARCH_REG_W-1:0];
    d.rs2               = rs2[`ARCH_REG_W-1:0];
    d.operand.br.cond   = cond;
    d.operand.br.offset = offset[`WORD_SIZE-3:0];
    return d;
  endfunction

  // program-order reference, fills the expected queues
  task automatic model_exec(input decoded_t ins);
    logic [`WORD_SIZE-1:0] a;
    logic [`WORD_SIZE-1:0] b;
    logic [`WORD_SIZE-1:0] res;
    logic [`WORD_SIZE-3:0] off;
    logic                  taken;
    a     = model_rf[ins.rs1];
    b     = model_rf[ins.rs2];
    off   = ins.operand.br.offset;
    res   = '0;
    taken = 1'b0;
    case (ins.op)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_ADDI: res = a + ins.operand.imm;
      default:
        case (ins.operand.br.cond)
          BR_EQ:   taken = (a == b);
          BR_NE:   taken = (a != b);
          BR_LT:   taken = ($signed(a) < $signed(b));
          default: taken = 1'b1;
        endcase
    endcase
    if (ins.op == OP_BR)
    begin
      if (taken)
      begin
        last_target = ins.pc + {{2{off[`WORD_SIZE-3]}}, off} * 32'd4;
        exp_pc.push_back(last_target);
      end
    end
    else
    begin
      model_rf[ins.rd] = res;
      exp_rd.push_back(ins.rd);
      exp_val.push_back(res);
    end
  endtask

  // present one instruction and hold it until accepted
  task automatic send(input decoded_t ins, input bit retires);
    int waited;
    waited  = 0;
    ins.pc  = next_pc;
    next_pc = next_pc + 32'd4;
    if (retires)
      model_exec(ins);
    decoded_i   = ins;
    decoded_v_i = 1'b1;
    @(negedge clk_i);
    while (!rename_decode_ready_o)
    begin
      stall_cycles++;
      waited++;
      if (waited > 200)
        stop_with_fail("timeout: an instruction was never accepted by rename");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic idle(input int n);
    decoded_v_i = 1'b0;
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles      = 0;
    decoded_v_i = 1'b0;
    do
    begin
      @(posedge clk_i);
      cycles++;
      if (cycles > 500)
        stop_with_fail("timeout: expected retirements did not arrive");
    end
    while (exp_rd.size() != 0 || exp_pc.size() != 0);
    #1;
  endtask

  // retirement and redirect checks, sampled mid-cycle
  always @(negedge clk_i)
  begin
    if (rst_n_i && commit_v_o)
    begin
      assert (exp_rd.size() > 0)
        else stop_with_fail($sformatf("unexpected retirement of r%0d", commit_rd_o));
      if (exp_rd.size() > 0)
      begin
        assert (commit_rd_o == exp_rd[0] && commit_data_o == exp_val[0])
          else stop_with_fail(err_line($sformatf("retired r%0d = %h, expected r%0d = %h",
                                       commit_rd_o, commit_data_o, exp_rd[0], exp_val[0])));
        void'(exp_rd.pop_front());
        void'(exp_val.pop_front());
      end
    end
    if (rst_n_i && be_fe_mispredict_o)
    begin
      assert (exp_pc.size() > 0)
        else stop_with_fail("mispredict pulse without a pending taken branch");
      if (exp_pc.size() > 0)
      begin
        assert (be_fe_redirected_pc_o == exp_pc[0])
          else stop_with_fail(err_line($sformatf("redirect pc %h, expected %h",
                                       be_fe_redirected_pc_o, exp_pc[0])));
        void'(exp_pc.pop_front());
      end
    end
  end

  task automatic test_reset();
    @(negedge clk_i);
    assert (rename_decode_ready_o && !commit_v_o && !be_fe_mispredict_o)
      else stop_with_fail(err_line("outputs after reset are not idle"));
    @(posedge clk_i);
    #1;
  endtask

  task automatic test_independent();
    send(alu_op(OP_ADDI, 1, 0, 0, 32'd7), 1'b1);
    send(alu_op(OP_ADDI, 2, 0, 0, -32'sd3), 1'b1);
    send(alu_op(OP_ADDI, 3, 0, 0, 32'd100), 1'b1);
    send(alu_op(OP_ADD, 4, 1, 2, '0), 1'b1);
    send(alu_op(OP_SUB, 5, 3, 1, '0), 1'b1);
    send(alu_op(OP_SUB, 6, 2, 3, '0), 1'b1);
    send(alu_op(OP_ADD, 7, 4, 5, '0), 1'b1);
    wait_drain();
  endtask

  task automatic test_raw_chain();
    for (int k = 1; k <= 6; k++)
      send(alu_op(OP_ADDI, 7, 7, 0, k), 1'b1);
    send(alu_op(OP_ADD, 6, 7, 7, '0), 1'b1);
    send(alu_op(OP_SUB, 5, 6, 7, '0), 1'b1);
    wait_drain();
  endtask

  task automatic test_taken_branch();
    send(branch(BR_ALWAYS, 0, 0, 16), 1'b1);
    // wrong-path instructions, flushed by the branch
    send(alu_op(OP_ADDI, 1, 1, 0, 32'd1000), 1'b0);
    send(alu_op(OP_ADD, 2, 1, 1, '0), 1'b0);
    wait_drain();
    idle(10);
    next_pc = last_target;
    send(alu_op(OP_ADD, 3, 1, 2, '0), 1'b1);
    send(branch(BR_EQ, 4, 4, -8), 1'b1);
    send(alu_op(OP_SUB, 4, 4, 3, '0), 1'b0);
    wait_drain();
    idle(10);
    next_pc = last_target;
    send(alu_op(OP_ADD, 5, 4, 3, '0), 1'b1);
    wait_drain();
  endtask

  task automatic test_not_taken();
    send(branch(BR_NE, 3, 3, 40), 1'b1);
    send(alu_op(OP_ADDI, 6, 3, 0, 32'd9), 1'b1);
    send(alu_op(OP_ADD, 7, 6, 5, '0), 1'b1);
    wait_drain();
  endtask

  task automatic test_random_stream();
    logic [31:0] r;
    op_e         op;
    int          rd;
    int          rs1;
    int          rs2;
    int          stalls_before;
    stalls_before = stall_cycles;
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      r   = rand_bits(2);
      op  = op_e'(r[1:0]);
      rd  = int'(rand_bits(3));
      rs1 = int'(rand_bits(3));
      rs2 = int'(rand_bits(3));
      r   = rand_bits(16);
      // equal operands keep NE branches not taken
      if (op == OP_BR)
        send(branch(BR_NE, rs1, rs1, int'($signed(r[7:0]))), 1'b1);
      else
        send(alu_op(op, rd, rs1, rs2, {{16{r[15]}}, r[15:0]}), 1'b1);
    end
    wait_drain();
    // a full window must have pushed back on decode
    assert (stall_cycles > stalls_before)
      else stop_with_fail("random stream never saw back-pressure from rename");
    $display("random stream done, %0d stall cycles", stall_cycles - stalls_before);
  endtask

  initial
  begin
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    decoded_i    = '0;
    decoded_v_i  = 1'b0;
    lfsr         = 32'hcfa3_81db;
    next_pc      = 32'h0000_1000;
    last_target  = '0;
    stall_cycles = 0;
    for (int a = 0; a < `NUM_ARCH_REG; a++)
      model_rf[a] = '0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    test_reset();
    test_independent();
    test_raw_chain();
    test_taken_branch();
    test_not_taken();
    test_random_stream();
    if (exp_rd.size() == 0 && exp_pc.size() == 0)
    begin
      $display("STATUS: PASS");
      $finish;
    end
    else
      stop_with_fail("expected retirements still pending at the end of the run");
  end

  initial
  begin
    #(WATCHDOG_NS);
    stop_with_fail($sformatf("timeout: run exceeded %0d ns", WATCHDOG_NS));
  end

endmodule

`default_nettype wire

//--- rtl/be_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "be_consts.svh"

module be_top
  ( input  logic                    clk_i
  , input  logic                    rst_n_i
  // front end to rename
  , input  be_instr_pkg::decoded_t  decoded_i
  , input  logic                    decoded_v_i
  , output logic                    rename_decode_ready_o
  // redirect to front end
  , output logic                    be_fe_mispredict_o
  , output logic [`WORD_SIZE-1:0]   be_fe_redirected_pc_o
  // retirement
  , output logic                    commit_v_o
  , output logic [`ARCH_REG_W-1:0]  commit_rd_o
  , output logic [`WORD_SIZE-1:0]   commit_data_o
  );

  import be_ooo_pkg::*;

  renamed_t  rename_issue;
  logic      rename_issue_v;
  logic      issue_rename_ready;
  issued_t   issue_exe;
  logic      issue_exe_v;
  cdb_t      cdb;
  logic      flush;

  rob_alloc_if rob_alloc ();
  prf_read_if  prf_read ();
  retire_if    retire ();

  rename_stage rename
    (  .clk_i                 (clk_i)
     , .rst_n_i               (rst_n_i)
     , .decoded_i             (decoded_i)
     , .decoded_v_i           (decoded_v_i)
     , .rename_decode_ready_o (rename_decode_ready_o)
     , .renamed_o             (rename_issue)
     , .renamed_v_o           (rename_issue_v)
     , .issue_ready_i         (issue_rename_ready)
     , .flush_i               (flush)
     , .rob_alloc             (rob_alloc)
     , .retire                (retire)
    );

  issue_table issue
    (  .clk_i         (clk_i)
     , .rst_n_i       (rst_n_i)
     , .renamed_i     (rename_issue)
     , .renamed_v_i   (rename_issue_v)
     , .issue_ready_o (issue_rename_ready)
     , .prf_read      (prf_read)
     , .cdb_i         (cdb)
     , .issue_o       (issue_exe)
     , .issue_v_o     (issue_exe_v)
     , .flush_i       (flush)
    );

  execute_stage execute
    (  .clk_i     (clk_i)
     , .rst_n_i   (rst_n_i)
     , .issue_i   (issue_exe)
     , .issue_v_i (issue_exe_v)
     , .flush_i   (flush)
     , .cdb_o     (cdb)
    );

  commit_stage commit
    (  .clk_i           (clk_i)
     , .rst_n_i         (rst_n_i)
     , .rob_alloc       (rob_alloc)
     , .prf_read        (prf_read)
     , .cdb_i           (cdb)
     , .retire          (retire)
     , .flush_o         (flush)
     , .mispredict_o    (be_fe_mispredict_o)
     , .redirected_pc_o (be_fe_redirected_pc_o)
     , .commit_v_o      (commit_v_o)
     , .commit_rd_o     (commit_rd_o)
     , .commit_data_o   (commit_data_o)
    );

endmodule

`default_nettype wire

//--- rtl/commit_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "be_consts.svh"

module commit_stage
  ( input  logic                    clk_i
  , input  logic                    rst_n_i
  , rob_alloc_if.commit             rob_alloc
  , prf_read_if.commit              prf_read
  , input  be_ooo_pkg::cdb_t        cdb_i
  , retire_if.commit                retire
  , output logic                    flush_o
  // front end redirect
  , output logic                    mispredict_o
  , output logic [`WORD_SIZE-1:0]   redirected_pc_o
  // retirement report
  , output logic                    commit_v_o
  , output logic [`ARCH_REG_W-1:0]  commit_rd_o
  , output logic [`WORD_SIZE-1:0]   commit_data_o
  );

  import be_ooo_pkg::*;

  rob_entry_t                rob [`ROB_ENTRY];
  // one extra bit tells full from empty
  logic [`ROB_TAG_W:0]       head_q, tail_q;
  logic [`WORD_SIZE-1:0]     prf [`NUM_PHYS_REG];
  logic [`NUM_PHYS_REG-1:0]  prf_v;
  rob_entry_t                head;
  logic                      head_done;

  assign head      = rob[head_q[`ROB_TAG_W-1:0]];
  assign head_done = (head_q != tail_q) && head.done;

  assign commit_v_o      = head_done && !head.is_br;
  assign commit_rd_o     = head.ard;
  assign commit_data_o   = prf[head.prd];
  assign mispredict_o    = head_done && head.is_br && head.taken;
  assign redirected_pc_o = head.target;
  assign flush_o         = mispredict_o;

  assign retire.valid   = commit_v_o;
  assign retire.ard     = head.ard;
  assign retire.prd     = head.prd;
  assign retire.old_prd = head.old_prd;

  assign rob_alloc.ready = !((head_q[`ROB_TAG_W] != tail_q[`ROB_TAG_W])
                             && (head_q[`ROB_TAG_W-1:0] == tail_q[`ROB_TAG_W-1:0]));
  assign rob_alloc.tag   = tail_q[`ROB_TAG_W-1:0];

  assign prf_read.data1  = prf[prf_read.addr1];
  assign prf_read.data2  = prf[prf_read.addr2];
  assign prf_read.valid1 = prf_v[prf_read.addr1];
  assign prf_read.valid2 = prf_v[prf_read.addr2];

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      head_q <= '0;
      tail_q <= '0;
    end
    else if (flush_o)
    begin
      // the mispredicted branch is the head, so every other entry is younger
      head_q <= '0;
      tail_q <= '0;
    end
    else
    begin
      if (head_done)
        head_q <= head_q + 1'b1;
      if (rob_alloc.valid)
        tail_q <= tail_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cdb_i.valid)
    begin
      rob[cdb_i.rob_tag].done   <= 1'b1;
      rob[cdb_i.rob_tag].taken  <= cdb_i.taken;
      rob[cdb_i.rob_tag].target <= cdb_i.target;
    end
    if (rob_alloc.valid)
      rob[tail_q[`ROB_TAG_W-1:0]] <= '{done:    1'b0,
                                      ard:     rob_alloc.ard,
                                      prd:     rob_alloc.prd,
                                      old_prd: rob_alloc.old_prd,
                                      is_br:   rob_alloc.is_br,
                                      taken:   1'b0,
                                      target:  '0};
  end

  // physical registers, all zero and valid out of reset
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int p = 0; p < `NUM_PHYS_REG; p++)
        prf[p] <= '0;
      prf_v <= '1;
    end
    else
    begin
      if (cdb_i.valid && cdb_i.wr)
      begin
        prf[cdb_i.prd]   <= cdb_i.result;
        prf_v[cdb_i.prd] <= 1'b1;
      end
      if (rob_alloc.valid && !rob_alloc.is_br)
        prf_v[rob_alloc.prd] <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "be_consts.svh"

module execute_stage
  ( input  logic                 clk_i
  , input  logic                 rst_n_i
  , input  be_ooo_pkg::issued_t  issue_i
  , input  logic                 issue_v_i
  , input  logic                 flush_i
  , output be_ooo_pkg::cdb_t     cdb_o
  );

  import be_instr_pkg::*;

  logic [`WORD_SIZE-1:0]  a, b, result, target;
  br_operand_t            br;
  logic                   taken;

  assign a  = issue_i.val1;
  assign b  = issue_i.val2;
  assign br = issue_i.instr.operand.br;

  // word offset scaled to bytes
  assign target = issue_i.instr.pc + {br.offset, 2'b00};

  always_comb
  begin
    result = '0;
    taken  = 1'b0;
    case (issue_i.instr.op)
      OP_ADD:  result = a + b;
      OP_SUB:  result = a - b;
      OP_ADDI: result = a + issue_i.instr.operand.imm;
      default:
        case (br.cond)
          BR_EQ:   taken = a == b;
          BR_NE:   taken = a != b;
          BR_LT:   taken = $signed(a) < $signed(b);
          default: taken = 1'b1;
        endcase
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      cdb_o <= '0;
    else
    begin
      // nothing younger than a mispredict may reach the bus
      cdb_o.valid   <= issue_v_i && !flush_i;
      cdb_o.rob_tag <= issue_i.instr.rob_tag;
      cdb_o.prd     <= issue_i.instr.prd;
      cdb_o.wr      <= issue_i.instr.op != OP_BR;
      cdb_o.result  <= result;
      cdb_o.taken   <= taken;
      cdb_o.target  <= target;
    end
  end

endmodule

`default_nettype wire

//--- rtl/issue_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "be_consts.svh"

module issue_table
  ( input  logic                   clk_i
  , input  logic                   rst_n_i
  , input  be_ooo_pkg::renamed_t   renamed_i
  , input  logic                   renamed_v_i
  , output logic                   issue_ready_o
  , prf_read_if.issue              prf_read
  , input  be_ooo_pkg::cdb_t       cdb_i
  , output be_ooo_pkg::issued_t    issue_o
  , output logic                   issue_v_o
  , input  logic                   flush_i
  );

  import be_ooo_pkg::*;

  renamed_t                 slot_instr [`ISSUE_ENTRY];
  logic [`WORD_SIZE-1:0]    slot_val1  [`ISSUE_ENTRY];
  logic [`WORD_SIZE-1:0]    slot_val2  [`ISSUE_ENTRY];
  logic [`ISSUE_ENTRY-1:0]  slot_v, rdy1, rdy2;
  // older[i][j] set when slot j was written before slot i
  logic [`ISSUE_ENTRY-1:0]  older [`ISSUE_ENTRY];
  logic [`ISSUE_ENTRY-1:0]  ready_vec, wake1, wake2;
  logic [`ISSUE_IDX_W-1:0]  ins_idx, sel_idx;
  logic                     ins, hit1, hit2;

  assign issue_ready_o  = ~&slot_v;
  assign ins            = renamed_v_i && issue_ready_o && !flush_i;
  assign prf_read.addr1 = renamed_i.prs1;
  assign prf_read.addr2 = renamed_i.prs2;

  // a result on the bus in the insert cycle is not yet in the register file
  assign hit1 = cdb_i.valid && cdb_i.wr && cdb_i.prd == renamed_i.prs1;
  assign hit2 = cdb_i.valid && cdb_i.wr && cdb_i.prd == renamed_i.prs2;

  always_comb
  begin
    for (int i = 0; i < `ISSUE_ENTRY; i++)
    begin
      wake1[i] = cdb_i.valid && cdb_i.wr && !rdy1[i] && cdb_i.prd == slot_instr[i].prs1;
      wake2[i] = cdb_i.valid && cdb_i.wr && !rdy2[i] && cdb_i.prd == slot_instr[i].prs2;
    end
  end

  assign ready_vec = slot_v & rdy1 & rdy2;

  always_comb
  begin
    ins_idx = '0;
    for (int i = `ISSUE_ENTRY-1; i >= 0; i--)
    begin
      if (!slot_v[i])
        ins_idx = i[`ISSUE_IDX_W-1:0];
    end
  end

  // oldest ready slot has no older ready slot
  always_comb
  begin
    sel_idx   = '0;
    issue_v_o = 1'b0;
    for (int i = 0; i < `ISSUE_ENTRY; i++)
    begin
      if (ready_vec[i] && !(|(older[i] & ready_vec)))
      begin
        sel_idx   = i[`ISSUE_IDX_W-1:0];
        issue_v_o = 1'b1;
      end
    end
  end

  assign issue_o.instr = slot_instr[sel_idx];
  assign issue_o.val1  = slot_val1[sel_idx];
  assign issue_o.val2  = slot_val2[sel_idx];

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      slot_v <= '0;
      rdy1   <= '0;
      rdy2   <= '0;
      for (int i = 0; i < `ISSUE_ENTRY; i++)
        older[i] <= '0;
    end
    else if (flush_i)
      slot_v <= '0;
    else
    begin
      rdy1 <= rdy1 | wake1;
      rdy2 <= rdy2 | wake2;
      if (issue_v_o)
        slot_v[sel_idx] <= 1'b0;
      if (ins)
      begin
        slot_v[ins_idx] <= 1'b1;
        rdy1[ins_idx]   <= prf_read.valid1 || hit1;
        rdy2[ins_idx]   <= prf_read.valid2 || hit2;
        // new entry is younger than everything present
        for (int i = 0; i < `ISSUE_ENTRY; i++)
          older[i][ins_idx] <= 1'b0;
        older[ins_idx] <= slot_v;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    for (int i = 0; i < `ISSUE_ENTRY; i++)
    begin
      if (wake1[i])
        slot_val1[i] <= cdb_i.result;
      if (wake2[i])
        slot_val2[i] <= cdb_i.result;
    end
    if (ins)
    begin
      slot_instr[ins_idx] <= renamed_i;
      slot_val1[ins_idx]  <= hit1 ? cdb_i.result : prf_read.data1;
      slot_val2[ins_idx]  <= hit2 ? cdb_i.result : prf_read.data2;
    end
  end

endmodule

`default_nettype wire

//--- rtl/rename_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "be_consts.svh"

module rename_stage
  ( input  logic                    clk_i
  , input  logic                    rst_n_i
  // decode side
  , input  be_instr_pkg::decoded_t  decoded_i
  , input  logic                    decoded_v_i
  , output logic                    rename_decode_ready_o
  // toward issue
  , output be_ooo_pkg::renamed_t    renamed_o
  , output logic                    renamed_v_o
  , input  logic                    issue_ready_i
  , input  logic                    flush_i
  , rob_alloc_if.rename             rob_alloc
  , retire_if.rename                retire
  );

  import be_instr_pkg::*;

  logic [`PHYS_REG_W-1:0]    spec_map   [`NUM_ARCH_REG];
  logic [`PHYS_REG_W-1:0]    retire_map [`NUM_ARCH_REG];
  logic [`NUM_PHYS_REG-1:0]  free_q;
  logic [`NUM_PHYS_REG-1:0]  retire_used;
  logic [`PHYS_REG_W-1:0]    new_prd;
  logic                      needs_rd;
  logic                      accept;

  // lowest free register wins
  always_comb
  begin
    new_prd = '0;
    for (int p = `NUM_PHYS_REG-1; p >= 0; p--)
    begin
      if (free_q[p])
        new_prd = p[`PHYS_REG_W-1:0];
    end
  end

  // registers held by the committed state, used to rebuild the free list
  always_comb
  begin
    retire_used = '0;
    for (int a = 0; a < `NUM_ARCH_REG; a++)
      retire_used[retire_map[a]] = 1'b1;
  end

  assign needs_rd = decoded_i.op != OP_BR;
  assign rename_decode_ready_o = issue_ready_i && rob_alloc.ready && !flush_i
                                 && (|free_q || !needs_rd);
  assign accept = decoded_v_i && rename_decode_ready_o;

  assign rob_alloc.valid   = accept;
  assign rob_alloc.ard     = decoded_i.rd;
  assign rob_alloc.prd     = new_prd;
  assign rob_alloc.old_prd = spec_map[decoded_i.rd];
  assign rob_alloc.is_br   = !needs_rd;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int a = 0; a < `NUM_ARCH_REG; a++)
      begin
        spec_map[a]   <= a[`PHYS_REG_W-1:0];
        retire_map[a] <= a[`PHYS_REG_W-1:0];
      end
      free_q <= {{(`NUM_PHYS_REG-`NUM_ARCH_REG){1'b1}}, {`NUM_ARCH_REG{1'b0}}};
    end
    else if (flush_i)
    begin
      spec_map <= retire_map;
      free_q   <= ~retire_used;
    end
    else
    begin
      if (retire.valid)
      begin
        retire_map[retire.ard] <= retire.prd;
        free_q[retire.old_prd] <= 1'b1;
      end
      if (accept && needs_rd)
      begin
        spec_map[decoded_i.rd] <= new_prd;
        free_q[new_prd]        <= 1'b0;
      end
    end
  end

  // output register, held while issue is full
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      renamed_v_o <= 1'b0;
    else if (flush_i)
      renamed_v_o <= 1'b0;
    else if (accept)
      renamed_v_o <= 1'b1;
    else if (issue_ready_i)
      renamed_v_o <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      renamed_o <= '{op:      decoded_i.op,
                     operand: decoded_i.operand,
                     pc:      decoded_i.pc,
                     prd:     new_prd,
                     prs1:    spec_map[decoded_i.rs1],
                     prs2:    spec_map[decoded_i.rs2],
                     rob_tag: rob_alloc.tag};
  end

endmodule

`default_nettype wire

//--- rtl/be_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "be_consts.svh"

// rename allocates one reorder-buffer entry per accepted instruction
interface rob_alloc_if;
  logic                    valid;
  logic [`ARCH_REG_W-1:0]  ard;
  logic [`PHYS_REG_W-1:0]  prd;
  logic [`PHYS_REG_W-1:0]  old_prd;
  logic                    is_br;
  logic                    ready;
  logic [`ROB_TAG_W-1:0]   tag;

  modport rename (output valid, ard, prd, old_prd, is_br, input ready, tag);
  modport commit (input valid, ard, prd, old_prd, is_br, output ready, tag);
endinterface

// combinational operand read on insert
interface prf_read_if;
  logic [`PHYS_REG_W-1:0]  addr1;
  logic [`PHYS_REG_W-1:0]  addr2;
  logic [`WORD_SIZE-1:0]   data1;
  logic [`WORD_SIZE-1:0]   data2;
  logic                    valid1;
  logic                    valid2;

  modport issue  (output addr1, addr2, input data1, data2, valid1, valid2);
  modport commit (input addr1, addr2, output data1, data2, valid1, valid2);
endinterface

interface retire_if;
  logic                    valid;
  logic [`ARCH_REG_W-1:0]  ard;
  logic [`PHYS_REG_W-1:0]  prd;
  logic [`PHYS_REG_W-1:0]  old_prd;

  modport commit (output valid, ard, prd, old_prd);
  modport rename (input valid, ard, prd, old_prd);
endinterface

`default_nettype wire

//--- rtl/be_ooo_pkg.sv
`default_nettype none

`include "be_consts.svh"

package be_ooo_pkg;

  typedef struct packed {
    be_instr_pkg::op_e       op;
    be_instr_pkg::operand_u  operand;
    logic [`WORD_SIZE-1:0]   pc;
    logic [`PHYS_REG_W-1:0]  prd;
    logic [`PHYS_REG_W-1:0]  prs1;
    logic [`PHYS_REG_W-1:0]  prs2;
    logic [`ROB_TAG_W-1:0]   rob_tag;
  } renamed_t;

  // renamed instruction plus captured operands
  typedef struct packed {
    renamed_t               instr;
    logic [`WORD_SIZE-1:0]  val1;
    logic [`WORD_SIZE-1:0]  val2;
  } issued_t;

  // wr is low for branches, which have no destination
  typedef struct packed {
    logic                    valid;
    logic [`ROB_TAG_W-1:0]   rob_tag;
    logic [`PHYS_REG_W-1:0]  prd;
    logic                    wr;
    logic [`WORD_SIZE-1:0]   result;
    logic                    taken;
    logic [`WORD_SIZE-1:0]   target;
  } cdb_t;

  typedef struct packed {
    logic                    done;
    logic [`ARCH_REG_W-1:0]  ard;
    logic [`PHYS_REG_W-1:0]  prd;
    logic [`PHYS_REG_W-1:0]  old_prd;
    logic                    is_br;
    logic                    taken;
    logic [`WORD_SIZE-1:0]   target;
  } rob_entry_t;

endpackage

`default_nettype wire

//--- rtl/be_instr_pkg.sv
`default_nettype none

`include "be_consts.svh"

package be_instr_pkg;

  typedef enum logic [1:0] {
    OP_ADD,
    OP_SUB,
    OP_ADDI,
    OP_BR
  } op_e;

  typedef enum logic [1:0] {
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_ALWAYS
  } br_cond_e;

  // branch view, offset counted in words
  typedef struct packed {
    br_cond_e                      cond;
    logic signed [`WORD_SIZE-3:0]  offset;
  } br_operand_t;

  // ADDI reads imm, BR reads br
  typedef union packed {
    logic signed [`WORD_SIZE-1:0]  imm;
    br_operand_t                   br;
  } operand_u;

  typedef struct packed {
    logic [`WORD_SIZE-1:0]   pc;
    op_e                     op;
    logic [`ARCH_REG_W-1:0]  rd;
    logic [`ARCH_REG_W-1:0]  rs1;
    logic [`ARCH_REG_W-1:0]  rs2;
    operand_u                operand;
  } decoded_t;

endpackage

`default_nettype wire

//--- rtl/be_consts.svh
`ifndef BE_CONSTS_SVH
`define BE_CONSTS_SVH

// data path and pc width
`define WORD_SIZE    32

// register files
`define NUM_ARCH_REG 8
`define NUM_PHYS_REG 16

// window sizes
`define ROB_ENTRY    8
`define ISSUE_ENTRY  4

// index widths
`define ARCH_REG_W   $clog2(`NUM_ARCH_REG)
`define PHYS_REG_W   $clog2(`NUM_PHYS_REG)
`define ROB_TAG_W    $clog2(`ROB_ENTRY)
`define ISSUE_IDX_W  $clog2(`ISSUE_ENTRY)

`endif
